/* include/l2_params.svh */
`ifndef L2_PARAMS_SVH
`define L2_PARAMS_SVH

// byte address width seen by both L1 caches and the memory bridge
`define L2_ADDR_W   32

// four sets
`define L2_INDEX_W  2

// word offset inside a line of four words
`define L2_OFFSET_W 2

// ways 0 and 1 belong to the icache, 2 and 3 to the dcache
`define L2_WAYS     4
`define L2_WAY_W    2

// one full line of four 32-bit words
`define L2_LINE_W   128

// what is left of the address above index, word offset and byte offset
`define L2_TAG_W    (`L2_ADDR_W - `L2_INDEX_W - `L2_OFFSET_W - 2)

`endif

/* logic/l2_bus_pkg.sv */
`default_nettype none

`include "l2_params.svh"

package l2_bus_pkg;

    // who the buffered request came from, and read or write on the data side
    typedef enum logic [1:0] {
        SRC_NONE   = 2'd0,
        SRC_IFETCH = 2'd1,
        SRC_DREAD  = 2'd2,
        SRC_DWRITE = 2'd3
    } l2_src_e;

    typedef struct packed {
        logic                 req;
        logic [`L2_ADDR_W-1:0] addr;
    } ic_req_t;

    typedef struct packed {
        logic                 req;
        logic                 wr;
        logic [`L2_ADDR_W-1:0] addr;
        logic [31:0]          wdata;
        logic [3:0]           wstrb;
    } dc_req_t;

    typedef struct packed {
        logic                 addr_ok;
        logic                 data_ok;
        logic [`L2_LINE_W-1:0] line;
    } l1_resp_t;

    typedef struct packed {
        l2_src_e              src;
        logic [`L2_ADDR_W-1:0] addr;
        logic [31:0]          wdata;
        logic [3:0]           wstrb;
    } l2_req_t;

    // memory side addresses are always line aligned
    typedef struct packed {
        logic                 req;
        logic [`L2_ADDR_W-1:0] addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic                 req;
        logic [`L2_ADDR_W-1:0] addr;
        logic [`L2_LINE_W-1:0] line;
    } mem_wr_req_t;

    typedef struct packed {
        logic                 addr_ok_r;
        logic                 addr_ok_w;
        logic                 data_ok;
        logic [`L2_LINE_W-1:0] line;
    } mem_resp_t;

endpackage

`default_nettype wire

/* logic/l2_ctrl_pkg.sv */
`default_nettype none

package l2_ctrl_pkg;

    // miss path runs write-back first, then the line read
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_LOOKUP  = 3'd1,
        ST_WB_REQ  = 3'd2,
        ST_RD_REQ  = 3'd3,
        // waiting for the read line
        ST_RD_WAIT = 3'd4,
        ST_REFILL  = 3'd5,
        // data_ok back to the L1 side
        ST_RESP    = 3'd6
    } l2_state_e;

endpackage

`default_nettype wire

/* logic/l2_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_params.svh"

module l2_arbiter import l2_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  ic_req_t               ic_req,
    input  dc_req_t               dc_req,
    input  logic                  grant,
    input  logic                  done,
    input  logic [`L2_LINE_W-1:0] line,
    output logic                  pending,
    output l2_src_e               src,
    output l2_req_t               req_buf,
    output l1_resp_t              ic_resp,
    output l1_resp_t              dc_resp
);

    // dcache first
    always_comb begin
        if (dc_req.req) begin
            src = dc_req.wr ? SRC_DWRITE : SRC_DREAD;
        end else if (ic_req.req) begin
            src = SRC_IFETCH;
        end else begin
            src = SRC_NONE;
        end
    end

    assign pending = ic_req.req | dc_req.req;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_buf.src <= SRC_NONE;
        end else if (grant) begin
            req_buf.src   <= src;
            req_buf.addr  <= dc_req.req ? dc_req.addr : ic_req.addr;
            req_buf.wdata <= dc_req.wdata;
            req_buf.wstrb <= dc_req.wstrb;
        end
    end

    // addr_ok follows the live winner, data_ok the buffered source
    always_comb begin
        ic_resp.addr_ok = grant && (src == SRC_IFETCH);
        ic_resp.data_ok = done && (req_buf.src == SRC_IFETCH);
        ic_resp.line    = line;

        dc_resp.addr_ok = grant && ((src == SRC_DREAD) || (src == SRC_DWRITE));
        dc_resp.data_ok = done && ((req_buf.src == SRC_DREAD) || (req_buf.src == SRC_DWRITE));
        dc_resp.line    = line;
    end

endmodule

`default_nettype wire

/* logic/l2_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_params.svh"

module l2_tag_store import l2_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  l2_req_t               req_buf,
    input  logic                  fill,
    input  logic                  set_dirty,
    input  logic [`L2_WAY_W-1:0]  fill_way,
    output logic [`L2_WAY_W-1:0]  hit_way,
    output logic                  hit,
    output logic [`L2_WAY_W-1:0]  victim_way,
    output logic                  victim_dirty,
    output logic [`L2_ADDR_W-1:0] victim_addr
);

    localparam int SETS = 1 << `L2_INDEX_W;

    logic [`L2_TAG_W-1:0]             tags [`L2_WAYS][SETS];
    logic [SETS-1:0][`L2_WAYS-1:0]    valid;
    logic [SETS-1:0][`L2_WAYS-1:0]    dirty;
    // one bit per side pointing at the way of the pair to replace next
    logic [SETS-1:0][1:0]             plru;

    logic [`L2_INDEX_W-1:0] idx;
    logic [`L2_TAG_W-1:0]   tag;
    logic                   side_d;
    logic [`L2_WAY_W-1:0]   way0;
    logic [`L2_WAY_W-1:0]   way1;
    logic                   hit0;
    logic                   hit1;

    assign idx    = req_buf.addr[`L2_OFFSET_W+`L2_INDEX_W+1:`L2_OFFSET_W+2];
    assign tag    = req_buf.addr[`L2_ADDR_W-1:`L2_OFFSET_W+`L2_INDEX_W+2];
    assign side_d = (req_buf.src != SRC_IFETCH);
    assign way0   = {side_d, 1'b0};
    assign way1   = {side_d, 1'b1};

    // only the pair visible to the requester is compared
    assign hit0    = valid[idx][way0] && (tags[way0][idx] == tag);
    assign hit1    = valid[idx][way1] && (tags[way1][idx] == tag);
    assign hit     = (req_buf.src != SRC_NONE) && (hit0 || hit1);
    assign hit_way = hit1 ? way1 : way0;

    always_comb begin
        if (!valid[idx][way0]) begin
            victim_way = way0;
        end else if (!valid[idx][way1]) begin
            victim_way = way1;
        end else begin
            victim_way = {side_d, plru[idx][side_d]};
        end
    end

    assign victim_dirty = valid[idx][victim_way] && dirty[idx][victim_way];
    assign victim_addr  = {tags[victim_way][idx], idx, {(`L2_OFFSET_W+2){1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
            plru  <= '0;
        end else begin
            if (fill) begin
                valid[idx][fill_way] <= 1'b1;
                dirty[idx][fill_way] <= set_dirty;
                plru[idx][fill_way[1]] <= ~fill_way[0];
            end else begin
                if (set_dirty) begin
                    dirty[idx][fill_way] <= 1'b1;
                end
                if (hit) begin
                    plru[idx][hit_way[1]] <= ~hit_way[0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[fill_way][idx] <= tag;
        end
    end

endmodule

`default_nettype wire

/* logic/l2_data_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_params.svh"

module l2_data_store import l2_bus_pkg::*; (
    input  logic                  clk,
    input  l2_req_t               req_buf,
    input  logic [`L2_WAY_W-1:0]  rd_way,
    input  logic                  word_we,
    input  logic                  line_we,
    input  logic [`L2_WAY_W-1:0]  wr_way,
    input  logic [`L2_LINE_W-1:0] refill_line,
    output logic [`L2_LINE_W-1:0] line
);

    localparam int SETS = 1 << `L2_INDEX_W;

    logic [`L2_LINE_W-1:0]   lines [SETS][`L2_WAYS];
    // memory line arrives with data_ok and is written one cycle later in refill
    logic [`L2_LINE_W-1:0]   refill_q;
    logic [`L2_LINE_W-1:0]   merged;
    logic [`L2_INDEX_W-1:0]  idx;
    logic [`L2_OFFSET_W-1:0] word;
    logic                    merge_en;

    assign idx      = req_buf.addr[`L2_OFFSET_W+`L2_INDEX_W+1:`L2_OFFSET_W+2];
    assign word     = req_buf.addr[`L2_OFFSET_W+1:2];
    assign merge_en = word_we || (line_we && (req_buf.src == SRC_DWRITE));

    // store word lands on top of either the old line or the refill line
    always_comb begin
        merged = line_we ? refill_q : lines[idx][wr_way];
        if (merge_en) begin
            for (int b = 0; b < 4; b++) begin
                if (req_buf.wstrb[b]) begin
                    merged[word*32 + b*8 +: 8] = req_buf.wdata[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        refill_q <= refill_line;
        if (line_we || word_we) begin
            lines[idx][wr_way] <= merged;
        end
    end

    assign line = lines[idx][rd_way];

endmodule

`default_nettype wire

/* logic/l2_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_params.svh"

module l2_ctrl_fsm import l2_bus_pkg::*, l2_ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pending,
    input  l2_src_e               src,
    input  logic                  hit,
    input  logic [`L2_WAY_W-1:0]  hit_way,
    input  logic [`L2_WAY_W-1:0]  victim_way,
    input  logic                  victim_dirty,
    input  logic [`L2_ADDR_W-1:0] victim_addr,
    input  logic [`L2_LINE_W-1:0] victim_line,
    input  logic [`L2_ADDR_W-1:0] req_addr,
    input  mem_resp_t             mem_resp,
    output logic                  grant,
    output logic                  done,
    output logic                  fill,
    output logic                  set_dirty,
    output logic                  word_we,
    output logic                  line_we,
    output logic [`L2_WAY_W-1:0]  rd_way,
    output logic [`L2_WAY_W-1:0]  wr_way,
    output mem_rd_req_t           mem_rd,
    output mem_wr_req_t           mem_wr
);

    l2_state_e            state;
    l2_state_e            state_nxt;
    l2_src_e              src_q;
    logic [`L2_WAY_W-1:0] way_q;
    logic [`L2_WAY_W-1:0] cur_way;
    logic                 is_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            src_q <= SRC_NONE;
        end else begin
            state <= state_nxt;
            if (grant) begin
                src_q <= src;
            end
        end
    end

    // hit way or victim way kept for the rest of the request
    always_ff @(posedge clk) begin
        if (state == ST_LOOKUP) begin
            way_q <= hit ? hit_way : victim_way;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (pending) begin
                    state_nxt = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit) begin
                    state_nxt = ST_RESP;
                end else if (victim_dirty) begin
                    state_nxt = ST_WB_REQ;
                end else begin
                    state_nxt = ST_RD_REQ;
                end
            end
            ST_WB_REQ: begin
                if (mem_resp.addr_ok_w) begin
                    state_nxt = ST_RD_REQ;
                end
            end
            ST_RD_REQ: begin
                // line may come back in the accept cycle
                if (mem_resp.addr_ok_r && mem_resp.data_ok) begin
                    state_nxt = ST_REFILL;
                end else if (mem_resp.addr_ok_r) begin
                    state_nxt = ST_RD_WAIT;
                end
            end
            ST_RD_WAIT: begin
                if (mem_resp.data_ok) begin
                    state_nxt = ST_REFILL;
                end
            end
            ST_REFILL: state_nxt = ST_RESP;
            ST_RESP:   state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    assign is_write = (src_q == SRC_DWRITE);
    assign cur_way  = (state == ST_LOOKUP) ? hit_way : way_q;

    assign grant     = (state == ST_IDLE) && pending;
    assign done      = (state == ST_RESP);
    assign fill      = (state == ST_REFILL);
    assign line_we   = (state == ST_REFILL);
    assign word_we   = (state == ST_LOOKUP) && hit && is_write;
    assign set_dirty = is_write && (((state == ST_LOOKUP) && hit) || (state == ST_REFILL));
    assign rd_way    = cur_way;
    assign wr_way    = cur_way;

    always_comb begin
        mem_rd.req  = (state == ST_RD_REQ);
        mem_rd.addr = {req_addr[`L2_ADDR_W-1:`L2_OFFSET_W+2], {(`L2_OFFSET_W+2){1'b0}}};
        mem_wr.req  = (state == ST_WB_REQ);
        mem_wr.addr = victim_addr;
        mem_wr.line = victim_line;
    end

endmodule

`default_nettype wire

/* logic/l2_cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_params.svh"

module l2_cache_top import l2_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  ic_req_t     ic_req,
    input  dc_req_t     dc_req,
    output l1_resp_t    ic_resp,
    output l1_resp_t    dc_resp,
    output mem_rd_req_t mem_rd,
    output mem_wr_req_t mem_wr,
    input  mem_resp_t   mem_resp
);

    l2_req_t               req_buf;
    l2_src_e               src;
    logic                  pending;
    logic                  grant;
    logic                  done;
    logic                  fill;
    logic                  set_dirty;
    logic                  word_we;
    logic                  line_we;
    logic                  hit;
    logic                  victim_dirty;
    logic [`L2_WAY_W-1:0]  hit_way;
    logic [`L2_WAY_W-1:0]  victim_way;
    logic [`L2_WAY_W-1:0]  rd_way;
    logic [`L2_WAY_W-1:0]  wr_way;
    logic [`L2_ADDR_W-1:0] victim_addr;
    logic [`L2_LINE_W-1:0] line;

    l2_arbiter i_l2_arbiter (
        .clk     (clk),
        .rst     (rst),
        .ic_req  (ic_req),
        .dc_req  (dc_req),
        .grant   (grant),
        .done    (done),
        .line    (line),
        .pending (pending),
        .src     (src),
        .req_buf (req_buf),
        .ic_resp (ic_resp),
        .dc_resp (dc_resp)
    );

    l2_tag_store i_l2_tag_store (
        .clk          (clk),
        .rst          (rst),
        .req_buf      (req_buf),
        .fill         (fill),
        .set_dirty    (set_dirty),
        .fill_way     (wr_way),
        .hit_way      (hit_way),
        .hit          (hit),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr)
    );

    l2_data_store i_l2_data_store (
        .clk         (clk),
        .req_buf     (req_buf),
        .rd_way      (rd_way),
        .word_we     (word_we),
        .line_we     (line_we),
        .wr_way      (wr_way),
        .refill_line (mem_resp.line),
        .line        (line)
    );

    l2_ctrl_fsm i_l2_ctrl_fsm (
        .clk          (clk),
        .rst          (rst),
        .pending      (pending),
        .src          (src),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_line  (line),
        .req_addr     (req_buf.addr),
        .mem_resp     (mem_resp),
        .grant        (grant),
        .done         (done),
        .fill         (fill),
        .set_dirty    (set_dirty),
        .word_we      (word_we),
        .line_we      (line_we),
        .rd_way       (rd_way),
        .wr_way       (wr_way),
        .mem_rd       (mem_rd),
        .mem_wr       (mem_wr)
    );

endmodule

`default_nettype wire

/* testbench/tb_mem_responder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_params.svh"

module tb_mem_responder import l2_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  mem_rd_req_t mem_rd,
    input  mem_wr_req_t mem_wr,
    input  logic [31:0] model_mem [0:2047],
    output mem_resp_t   mem_resp,
    output int          wb_count,
    output int          wb_errors
);

    // what the bridge really holds lags the model until write-back
    logic [31:0] backing [0:2047];

    task automatic pause_random();
        logic [31:0] d;
        d = $urandom_range(0, 5);
        repeat (d) @(posedge clk);
    endtask

    initial begin
        logic [10:0]  base;
        logic [127:0] exp_line;
        mem_resp <= '0;
        wb_count = 0;
        wb_errors = 0;
        // the model is filled at time zero
        @(posedge clk);
        for (int i = 0; i < 2048; i++) begin
            backing[i[10:0]] = model_mem[i[10:0]];
        end
        forever begin
            @(posedge clk);
            if (!rst && mem_wr.req) begin
                pause_random();
                base = {mem_wr.addr[12:4], 2'b00};
                exp_line = {model_mem[base + 11'd3], model_mem[base + 11'd2],
                            model_mem[base + 11'd1], model_mem[base]};
                wb_count++;
                if (mem_wr.addr[3:0] != 4'd0) begin
                    wb_errors++;
                    $display("CHECK FAILED at %0t: mem_wr.addr expected %h got %h", $time,
                             {mem_wr.addr[31:4], 4'd0}, mem_wr.addr);
                end
                if (mem_wr.line !== exp_line) begin
                    wb_errors++;
                    $display("CHECK FAILED at %0t: mem_wr.line expected %h got %h", $time,
                             exp_line, mem_wr.line);
                end
                backing[base]          = mem_wr.line[31:0];
                backing[base + 11'd1]  = mem_wr.line[63:32];
                backing[base + 11'd2]  = mem_wr.line[95:64];
                backing[base + 11'd3]  = mem_wr.line[127:96];
                mem_resp.addr_ok_w <= 1'b1;
                @(posedge clk);
                mem_resp.addr_ok_w <= 1'b0;
            end else if (!rst && mem_rd.req) begin
                pause_random();
                mem_resp.addr_ok_r <= 1'b1;
                @(posedge clk);
                mem_resp.addr_ok_r <= 1'b0;
                pause_random();
                base = {mem_rd.addr[12:4], 2'b00};
                mem_resp.line <= {backing[base + 11'd3], backing[base + 11'd2],
                                  backing[base + 11'd1], backing[base]};
                mem_resp.data_ok <= 1'b1;
                @(posedge clk);
                mem_resp.data_ok <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_l2_cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l2_params.svh"

module tb_l2_cache import l2_bus_pkg::*; ();

    localparam int MEM_WORDS = 2048;
    localparam int TIMEOUT   = 500;

    logic        clk = 1'b0;
    logic        rst;
    ic_req_t     ic_req;
    dc_req_t     dc_req;
    l1_resp_t    ic_resp;
    l1_resp_t    dc_resp;
    mem_rd_req_t mem_rd;
    mem_wr_req_t mem_wr;
    mem_resp_t   mem_resp;
    logic [31:0] model_mem [0:MEM_WORDS-1];
    int          wb_count;
    int          wb_errors;
    int          checks = 0;
    int          errors = 0;
    int          test_checks;
    int          test_errors;
    int          ic_addr_oks = 0;
    int          ic_data_oks = 0;
    int          dc_addr_oks = 0;
    int          dc_data_oks = 0;
    int          cnt0 [4];
    time         dc_ok_time;
    time         ic_ok_time;

    always #10 clk = ~clk;

    l2_cache_top i_l2_cache_top (
        .clk      (clk),
        .rst      (rst),
        .ic_req   (ic_req),
        .dc_req   (dc_req),
        .ic_resp  (ic_resp),
        .dc_resp  (dc_resp),
        .mem_rd   (mem_rd),
        .mem_wr   (mem_wr),
        .mem_resp (mem_resp)
    );

    tb_mem_responder i_mem_responder (
        .clk       (clk),
        .rst       (rst),
        .mem_rd    (mem_rd),
        .mem_wr    (mem_wr),
        .model_mem (model_mem),
        .mem_resp  (mem_resp),
        .wb_count  (wb_count),
        .wb_errors (wb_errors)
    );

    always @(posedge clk) begin
        if (ic_resp.addr_ok) ic_addr_oks++;
        if (ic_resp.data_ok) ic_data_oks++;
        if (dc_resp.addr_ok) dc_addr_oks++;
        if (dc_resp.data_ok) dc_data_oks++;
    end

    function automatic logic [31:0] fill_word(input logic [10:0] waddr);
        logic [31:0] a;
        a = {21'd0, waddr};
        return (a * 32'h9e3779b1) ^ (a << 7) ^ 32'h0badf00d;
    endfunction

    function automatic logic [127:0] model_line(input logic [31:0] addr);
        logic [10:0] base;
        base = {addr[12:4], 2'b00};
        return {model_mem[base + 11'd3], model_mem[base + 11'd2],
                model_mem[base + 11'd1], model_mem[base]};
    endfunction

    // data lines 0x000..0x3ff, instruction lines 0x1000..0x13ff
    function automatic logic [31:0] rand_data_addr();
        logic [31:0] r;
        r = $urandom_range(0, 255);
        return {22'd0, r[7:0], 2'b00};
    endfunction

    function automatic logic [31:0] rand_ic_addr();
        logic [31:0] r;
        r = $urandom_range(0, 255);
        return {19'd0, 1'b1, 2'b00, r[7:0], 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic abort_run(input string what);
        $display("%0t: %s", $time, what);
        $display("checks: %0d, errors: %0d", checks, errors + 1);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic dc_access(input logic wr, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] wstrb);
        int          n;
        logic [10:0] w;
        dc_req.req   <= 1'b1;
        dc_req.wr    <= wr;
        dc_req.addr  <= addr;
        dc_req.wdata <= wdata;
        dc_req.wstrb <= wstrb;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) abort_run("data request never got addr_ok");
        end while (!dc_resp.addr_ok);
        dc_req.req <= 1'b0;
        dc_ok_time = $time;
        // the model takes the write at acceptance
        if (wr) begin
            w = addr[12:2];
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) model_mem[w][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (dc_resp.addr_ok) abort_run("data side got a second addr_ok before data_ok");
            if (n > TIMEOUT) abort_run("data request never got data_ok");
        end while (!dc_resp.data_ok);
        if (wr) begin
            check_value("dc_resp.line after write", dc_resp.line, model_line(addr));
        end else begin
            check_value("dc_resp.line", dc_resp.line, model_line(addr));
        end
    endtask

    task automatic ic_access(input logic [31:0] addr);
        int n;
        ic_req.req  <= 1'b1;
        ic_req.addr <= addr;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT) abort_run("instruction request never got addr_ok");
        end while (!ic_resp.addr_ok);
        ic_req.req <= 1'b0;
        ic_ok_time = $time;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (ic_resp.addr_ok) abort_run("instruction side got a second addr_ok");
            if (n > TIMEOUT) abort_run("instruction request never got data_ok");
        end while (!ic_resp.data_ok);
        check_value("ic_resp.line", ic_resp.line, model_line(addr));
    endtask

    task automatic random_dc_op(input int write_pct);
        logic [31:0] r;
        logic [31:0] s;
        r = $urandom_range(0, 99);
        s = $urandom_range(1, 15);
        dc_access(r < write_pct, rand_data_addr(), $urandom, s[3:0]);
    endtask

    task automatic start_test();
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
    endtask

    initial begin
        void'($urandom(32'hdaddbab5));
        rst    <= 1'b1;
        ic_req <= '0;
        dc_req <= '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i[10:0]] = fill_word(i[10:0]);
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        start_test();
        repeat (10) begin
            @(posedge clk);
            check_value("addr_ok/data_ok/mem req", {122'd0, ic_resp.addr_ok, ic_resp.data_ok,
                        dc_resp.addr_ok, dc_resp.data_ok, mem_rd.req, mem_wr.req}, '0);
        end
        end_test("reset");

        start_test();
        repeat (60) random_dc_op(0);
        end_test("data_reads");

        start_test();
        repeat (200) random_dc_op(50);
        end_test("data_writes");

        start_test();
        repeat (30) ic_access(rand_ic_addr());
        // counters settle on the edge after the last data_ok
        @(posedge clk);
        cnt0 = '{ic_addr_oks, ic_data_oks, dc_addr_oks, dc_data_oks};
        fork
            // one idle edge between data requests lets the icache in
            repeat (100) begin
                @(posedge clk);
                random_dc_op(40);
            end
            repeat (100) ic_access(rand_ic_addr());
        join
        @(posedge clk);
        check_value("ic_resp.addr_ok count", {96'd0, ic_addr_oks - cnt0[0]}, {96'd0, 32'd100});
        check_value("ic_resp.data_ok count", {96'd0, ic_data_oks - cnt0[1]}, {96'd0, 32'd100});
        check_value("dc_resp.addr_ok count", {96'd0, dc_addr_oks - cnt0[2]}, {96'd0, 32'd100});
        check_value("dc_resp.data_ok count", {96'd0, dc_data_oks - cnt0[3]}, {96'd0, 32'd100});
        end_test("mixed_traffic");

        start_test();
        repeat (5) begin
            fork
                dc_access(1'b0, rand_data_addr(), 32'd0, 4'd0);
                ic_access(rand_ic_addr());
            join
            checks++;
            test_checks++;
            if (dc_ok_time >= ic_ok_time) begin
                errors++;
                test_errors++;
                $display("%0t: instruction side was accepted before the data side", $time);
            end
            @(posedge clk);
        end
        end_test("priority");

        start_test();
        checks += wb_count;
        test_checks += wb_count;
        errors += wb_errors;
        test_errors += wb_errors;
        if (wb_count == 0) begin
            errors++;
            test_errors++;
            $display("%0t: no write-back reached memory", $time);
        end
        end_test("write_backs");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
logic/l2_bus_pkg.sv
logic/l2_ctrl_pkg.sv
logic/l2_arbiter.sv
logic/l2_tag_store.sv
logic/l2_data_store.sv
logic/l2_ctrl_fsm.sv
logic/l2_cache_top.sv
testbench/tb_mem_responder.sv
testbench/tb_l2_cache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the L2 cache testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module tb_l2_cache -o sim_l2
./obj_dir/sim_l2 | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
